// File: build.f
src/ccu_pkt_pkg.sv
src/ccu_unpack_pkg.sv
src/ccu_ifs.sv
src/ccu_byte_fifo.sv
src/ccu_header_parser.sv
src/ccu_dispatch.sv
src/ccu_unpack.sv
bench/ccu_unpack_assert.sv
bench/tb_ccu_unpack.sv

// File: bench/tb_ccu_unpack.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ccu_unpack;
    import ccu_pkt_pkg::*;

    logic       axi_aclk;
    logic       axi_aresetn;
    byte_t      rdata;
    logic       rvalid;
    logic       rlast;
    logic       rready;
    logic       sys_dv, dac_dv, adc_dv;
    logic       sys_busy, dac_busy, adc_busy;
    pkt_id_t    pack_id;
    pkt_len_t   pack_length;
    pkt_type_t  pack_type;
    byte_t      pack_data;

    integer     seed = 32'h6a85bea0;
    logic       busy_on = 1'b0;
    int         bytes_total = 0;
    int         cycles = 0;
    string      test_name = "reset";
    byte_t      exp_data[$];
    pkt_id_t    exp_id[$];
    pkt_len_t   exp_len[$];
    pkt_type_t  exp_type[$];
    logic [2:0] exp_tgt[$];  // one-hot {adc, dac, sys}

    ccu_unpack DUT (.*);

    initial begin
        axi_aclk = 1'b0;
        forever #10 axi_aclk = ~axi_aclk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (act !== exp)
            fail_now($sformatf("ERROR %s pack_data: expected %h actual %h", name, exp, act));
    endtask

    task automatic check_id(input string name, input pkt_id_t exp, input pkt_id_t act);
        if (act !== exp)
            fail_now($sformatf("ERROR %s pack_id: expected %h actual %h", name, exp, act));
    endtask

    task automatic check_len(input string name, input pkt_len_t exp, input pkt_len_t act);
        if (act !== exp)
            fail_now($sformatf("ERROR %s pack_length: expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_type(input string name, input pkt_type_t exp, input pkt_type_t act);
        if (act !== exp)
            fail_now($sformatf("ERROR %s pack_type: expected %h actual %h", name, exp, act));
    endtask

    task automatic check_target(input string name, input logic [2:0] exp, input logic [2:0] act);
        if (act !== exp)
            fail_now($sformatf("ERROR %s dv {adc,dac,sys}: expected %b actual %b", name, exp, act));
    endtask

    // routed types hand over every byte in order and the rest hand over nothing
    function automatic logic [2:0] expected_bytes(input pkt_type_t ptype, input byte_t payload[$],
                                                  output byte_t deliver[$]);
        logic [2:0] tgt;
        case (ptype)
            TYPE_SYS_CTRL: tgt = 3'b001;
            TYPE_DATA_DAC: tgt = 3'b010;
            TYPE_REQ_ADC:  tgt = 3'b100;
            default:       tgt = 3'b000;
        endcase
        if (tgt != 3'b000) begin
            deliver = payload;
        end else begin
            deliver = {};
        end
        return tgt;
    endfunction

    task automatic cycle_start();
        logic [31:0] rnd;
        @(negedge axi_aclk);
        rnd = $random(seed);
        sys_busy = busy_on & rnd[0];
        dac_busy = busy_on & rnd[1];
        adc_busy = busy_on & rnd[2];
    endtask

    task automatic send_byte(input byte_t b);
        logic done;
        done = 1'b0;
        while (!done) begin
            cycle_start();
            rdata  = b;
            rvalid = ($random(seed) & 3) != 0;  // roughly one gap in four
            @(posedge axi_aclk);
            done = rvalid && rready;
        end
    endtask

    task automatic send_packet(input int n_junk, input pkt_id_t id, input logic [15:0] len_field,
                               input pkt_type_t ptype);
        byte_t      payload[$];
        byte_t      deliver[$];
        logic [2:0] tgt;
        pkt_len_t   n;
        byte_t      j;
        n = len_field[12:0];
        for (int i = 0; i < n; i++) begin
            payload.push_back(byte_t'($random(seed)));
        end
        tgt = expected_bytes(ptype, payload, deliver);
        foreach (deliver[i]) begin
            exp_data.push_back(deliver[i]);
            exp_id.push_back(id);
            exp_len.push_back(n);
            exp_type.push_back(ptype);
            exp_tgt.push_back(tgt);
        end
        bytes_total += n_junk + 6 + n;
        for (int i = 0; i < n_junk; i++) begin
            j = (i % 3 == 0) ? TYPE_DATA_DAC : byte_t'($random(seed));
            send_byte((j == SYNC_BYTE) ? 8'hA5 : j);
        end
        send_byte(SYNC_BYTE);
        send_byte(id[7:0]);
        send_byte(id[15:8]);
        send_byte(len_field[7:0]);
        send_byte(len_field[15:8]);
        send_byte(ptype);
        foreach (payload[i]) begin
            send_byte(payload[i]);
        end
        cycle_start();
        rvalid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_data.size() != 0 && waited < 1000) begin  // fifo holds at most 16
            cycle_start();
            rvalid = 1'b0;
            waited++;
        end
    endtask

    // compare on every edge where a byte is handed out
    always @(posedge axi_aclk) begin
        if (axi_aresetn === 1'b1 && (sys_dv || dac_dv || adc_dv)) begin
            if (exp_data.size() == 0) begin
                fail_now({test_name, ": a dv was raised with no payload byte expected"});
            end else if ((sys_dv && sys_busy) || (dac_dv && dac_busy) || (adc_dv && adc_busy)) begin
                fail_now({test_name, ": a dv was raised while its engine was busy"});
            end else begin
                check_target(test_name, exp_tgt.pop_front(), {adc_dv, dac_dv, sys_dv});
                check_byte(test_name, exp_data.pop_front(), pack_data);
                check_id(test_name, exp_id.pop_front(), pack_id);
                check_len(test_name, exp_len.pop_front(), pack_length);
                check_type(test_name, exp_type.pop_front(), pack_type);
            end
        end
    end

    initial begin
        forever begin
            @(posedge axi_aclk);
            cycles++;
            if (cycles > bytes_total * 40 + 2000)
                fail_now("timeout: the DUT stopped taking or delivering bytes");
        end
    end

    initial begin
        axi_aresetn = 1'b0;
        rdata       = '0;
        rvalid      = 1'b0;
        rlast       = 1'b0;
        sys_busy    = 1'b0;
        dac_busy    = 1'b0;
        adc_busy    = 1'b0;
        repeat (10) @(negedge axi_aclk);
        axi_aresetn = 1'b1;
        repeat (2) @(posedge axi_aclk);
        if (rready !== 1'b1 || (sys_dv | dac_dv | adc_dv) !== 1'b0)
            fail_now("after reset rready did not rise or a dv was high");

        test_name = "routed";
        send_packet(0, 16'h1234, 16'd5, TYPE_SYS_CTRL);
        send_packet(0, 16'hBEEF, 16'd7, TYPE_DATA_DAC);
        send_packet(0, 16'h0102, 16'd3, TYPE_REQ_ADC);
        wait_drain();

        test_name = "junk";
        send_packet(9, 16'h55AA, 16'd4, TYPE_DATA_DAC);
        wait_drain();

        test_name = "discard";
        send_packet(2, 16'h0001, 16'd6, TYPE_DATA_ADC);
        send_packet(0, 16'h0002, 16'd20, TYPE_REQ_DAC);
        send_packet(0, 16'h0003, 16'd5, 8'h7F);  // unknown code
        send_packet(0, 16'h0004, 16'd4, TYPE_SYS_CTRL);
        wait_drain();

        test_name = "busy";
        busy_on = 1'b1;
        send_packet(0, 16'hA001, 16'd40, TYPE_SYS_CTRL);
        send_packet(0, 16'hA002, 16'd40, TYPE_DATA_DAC);
        send_packet(0, 16'hA003, 16'd40, TYPE_REQ_ADC);
        wait_drain();
        busy_on = 1'b0;

        test_name = "zero_len";
        send_packet(0, 16'h0A0B, 16'd0, TYPE_SYS_CTRL);
        send_packet(0, 16'h0C0D, 16'd3, TYPE_REQ_ADC);
        send_packet(0, 16'h0E0F, 16'hE005, TYPE_DATA_DAC);  // upper bits ignored
        wait_drain();
        repeat (20) cycle_start();

        if (exp_data.size() == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            fail_now("expected payload bytes were never delivered");
        end
    end

endmodule

`default_nettype wire

// File: bench/ccu_unpack_assert.sv
`timescale 1ns/10ps
`default_nettype none

module ccu_unpack_assert (
    input logic axi_aclk,
    input logic axi_aresetn,
    input logic rready,
    input logic sys_dv, dac_dv, adc_dv,
    input logic sys_busy, dac_busy, adc_busy
);
    logic rst_seen;  // reset held over at least one edge

    always_ff @(posedge axi_aclk) begin
        rst_seen <= !axi_aresetn;
    end

    a_one_dv: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        $onehot0({sys_dv, dac_dv, adc_dv}))
        else $error("more than one dv high");

    a_busy_gate: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        !(sys_dv && sys_busy) && !(dac_dv && dac_busy) && !(adc_dv && adc_busy))
        else $error("dv high while its engine is busy");

    a_reset_quiet: assert property (@(posedge axi_aclk)
        (!axi_aresetn && rst_seen) |-> (!rready && !sys_dv && !dac_dv && !adc_dv))
        else $error("rready or a dv high during reset");

endmodule

bind ccu_unpack ccu_unpack_assert u_assert (
    .axi_aclk    (axi_aclk),
    .axi_aresetn (axi_aresetn),
    .rready      (rready),
    .sys_dv      (sys_dv),
    .dac_dv      (dac_dv),
    .adc_dv      (adc_dv),
    .sys_busy    (sys_busy),
    .dac_busy    (dac_busy),
    .adc_busy    (adc_busy)
);

`default_nettype wire

// File: src/ccu_unpack.sv
`timescale 1ns/10ps
`default_nettype none

module ccu_unpack (
    input  logic                  axi_aclk,
    input  logic                  axi_aresetn,

    // spi rx byte stream
    input  ccu_pkt_pkg::byte_t    rdata,
    input  logic                  rvalid,
    input  logic                  rlast,   // framing comes from the length field
    output logic                  rready,

    // command engines
    output logic                  sys_dv,
    output logic                  dac_dv,
    output logic                  adc_dv,
    input  logic                  sys_busy,
    input  logic                  dac_busy,
    input  logic                  adc_busy,

    // packet info, held for the whole packet
    output ccu_pkt_pkg::pkt_id_t   pack_id,
    output ccu_pkt_pkg::pkt_len_t  pack_length,
    output ccu_pkt_pkg::pkt_type_t pack_type,
    output ccu_pkt_pkg::byte_t     pack_data
);

    ccu_hdr_if  hdr_bus ();
    ccu_fifo_if fifo_bus ();

    ccu_header_parser u_parser (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .rdata       (rdata),
        .rvalid      (rvalid),
        .rready      (rready),
        .hdr         (hdr_bus.parser),
        .f           (fifo_bus.writer)
    );

    ccu_byte_fifo u_fifo (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .f           (fifo_bus.fifo)
    );

    ccu_dispatch u_dispatch (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .hdr         (hdr_bus.dispatch),
        .f           (fifo_bus.reader),
        .sys_busy    (sys_busy),
        .dac_busy    (dac_busy),
        .adc_busy    (adc_busy),
        .sys_dv      (sys_dv),
        .dac_dv      (dac_dv),
        .adc_dv      (adc_dv),
        .pack_data   (pack_data)
    );

    assign pack_id     = hdr_bus.pkt_id;
    assign pack_length = hdr_bus.pkt_len;
    assign pack_type   = hdr_bus.pkt_type;

endmodule

`default_nettype wire

// File: src/ccu_dispatch.sv
`timescale 1ns/10ps
`default_nettype none

module ccu_dispatch (
    input  logic               axi_aclk,
    input  logic               axi_aresetn,
    ccu_hdr_if.dispatch        hdr,
    ccu_fifo_if.reader         f,
    input  logic               sys_busy,
    input  logic               dac_busy,
    input  logic               adc_busy,
    output logic               sys_dv,
    output logic               dac_dv,
    output logic               adc_dv,
    output ccu_pkt_pkg::byte_t pack_data
);
    import ccu_pkt_pkg::*;
    import ccu_unpack_pkg::*;

    disp_state_e state;
    pkt_len_t    left;  // bytes still to hand out
    logic        to_sys;
    logic        to_dac;
    logic        to_adc;
    logic        blocked;
    logic        pop;

    always_comb begin
        to_sys = 1'b0;
        to_dac = 1'b0;
        to_adc = 1'b0;
        case (hdr.pkt_type)
            TYPE_SYS_CTRL: to_sys = 1'b1;
            TYPE_DATA_DAC: to_dac = 1'b1;
            TYPE_REQ_ADC:  to_adc = 1'b1;
            TYPE_DATA_ADC, TYPE_REQ_DAC: begin
                // no engine, payload is dropped
            end
            default: begin
            end
        endcase
    end

    // busy only stalls routed types
    assign blocked = (to_sys && sys_busy) || (to_dac && dac_busy) || (to_adc && adc_busy);
    assign pop     = (state == DRAIN) && (left != '0) && !f.empty && !blocked;

    assign f.rd_en = pop;
    assign sys_dv  = pop && to_sys;
    assign dac_dv  = pop && to_dac;
    assign adc_dv  = pop && to_adc;

    assign pack_data = (sys_dv || dac_dv || adc_dv) ? f.rdata : '0;

    // zero length finishes in the first hdr_valid cycle
    assign hdr.pkt_done = ((state == IDLE) && hdr.hdr_valid && (hdr.pkt_len == '0)) ||
                          ((state == DRAIN) && (left == '0));

    always_ff @(posedge axi_aclk) begin
        if (!axi_aresetn) begin
            state <= IDLE;
            left  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (hdr.hdr_valid && (hdr.pkt_len != '0)) begin
                        state <= DRAIN;
                        left  <= hdr.pkt_len;
                    end
                end
                DRAIN: begin
                    if (left == '0) begin
                        state <= IDLE;
                    end else if (pop) begin
                        left <= left - 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/ccu_header_parser.sv
`timescale 1ns/10ps
`default_nettype none

module ccu_header_parser (
    input  logic               axi_aclk,
    input  logic               axi_aresetn,
    input  ccu_pkt_pkg::byte_t rdata,
    input  logic               rvalid,
    output logic               rready,
    ccu_hdr_if.parser          hdr,
    ccu_fifo_if.writer         f
);
    import ccu_pkt_pkg::*;
    import ccu_unpack_pkg::*;

    parse_state_e state;
    pkt_len_t     wr_cnt;  // payload bytes taken so far
    logic         run;     // holds rready low through reset
    logic         xfer;

    assign rready = run && (state != WAIT_DONE) && !((state == PAYLOAD) && f.full);
    assign xfer   = rvalid && rready;

    assign f.wr_en = xfer && (state == PAYLOAD);
    assign f.wdata = rdata;

    always_ff @(posedge axi_aclk) begin
        if (!axi_aresetn) begin
            run           <= 1'b0;
            state         <= HUNT;
            wr_cnt        <= '0;
            hdr.pkt_id    <= '0;
            hdr.pkt_len   <= '0;
            hdr.pkt_type  <= '0;
            hdr.hdr_valid <= 1'b0;
        end else begin
            run <= 1'b1;
            case (state)
                HUNT: begin
                    if (xfer && (rdata == SYNC_BYTE)) begin
                        state <= ID_LO;
                    end
                end
                ID_LO: begin
                    if (xfer) begin
                        hdr.pkt_id[7:0] <= rdata;
                        state           <= ID_HI;
                    end
                end
                ID_HI: begin
                    if (xfer) begin
                        hdr.pkt_id[15:8] <= rdata;
                        state            <= LEN_LO;
                    end
                end
                LEN_LO: begin
                    if (xfer) begin
                        hdr.pkt_len[7:0] <= rdata;
                        state            <= LEN_HI;
                    end
                end
                LEN_HI: begin
                    if (xfer) begin
                        hdr.pkt_len[12:8] <= rdata[4:0];  // top 3 bits dropped
                        state             <= TYPE;
                    end
                end
                TYPE: begin
                    if (xfer) begin
                        hdr.pkt_type  <= rdata;
                        hdr.hdr_valid <= 1'b1;
                        wr_cnt        <= '0;
                        state         <= (hdr.pkt_len == '0) ? WAIT_DONE : PAYLOAD;
                    end
                end
                PAYLOAD: begin
                    if (xfer) begin
                        wr_cnt <= wr_cnt + 1'b1;
                        if (wr_cnt + 1'b1 == hdr.pkt_len) begin
                            state <= WAIT_DONE;  // last byte in
                        end
                    end
                end
                WAIT_DONE: begin
                    if (hdr.pkt_done) begin
                        hdr.hdr_valid <= 1'b0;
                        state         <= HUNT;
                    end
                end
                default: state <= HUNT;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/ccu_byte_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module ccu_byte_fifo (
    input logic      axi_aclk,
    input logic      axi_aresetn,
    ccu_fifo_if.fifo f
);
    import ccu_pkt_pkg::*;
    import ccu_unpack_pkg::*;

    byte_t     mem [FIFO_DEPTH];
    fifo_ptr_t wptr;
    fifo_ptr_t rptr;
    logic      do_wr;
    logic      do_rd;

    assign f.empty = (wptr == rptr);
    assign f.full  = (wptr[FIFO_AW] != rptr[FIFO_AW]) &&
                     (wptr[FIFO_AW-1:0] == rptr[FIFO_AW-1:0]);

    assign do_wr = f.wr_en && !f.full;
    assign do_rd = f.rd_en && !f.empty;

    assign f.rdata = mem[rptr[FIFO_AW-1:0]];  // head shows without a read

    always_ff @(posedge axi_aclk) begin
        if (!axi_aresetn) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (do_wr) begin
                wptr <= wptr + 1'b1;
            end
            if (do_rd) begin
                rptr <= rptr + 1'b1;
            end
        end
    end

    always_ff @(posedge axi_aclk) begin
        if (do_wr) begin
            mem[wptr[FIFO_AW-1:0]] <= f.wdata;
        end
    end

endmodule

`default_nettype wire

// File: src/ccu_ifs.sv
`timescale 1ns/10ps
`default_nettype none

// header fields, parser to dispatcher
interface ccu_hdr_if;
    import ccu_pkt_pkg::*;

    pkt_id_t   pkt_id;
    pkt_len_t  pkt_len;
    pkt_type_t pkt_type;
    logic      hdr_valid;  // high from type byte until after pkt_done
    logic      pkt_done;   // one-cycle pulse

    modport parser (
        output pkt_id, pkt_len, pkt_type, hdr_valid,
        input  pkt_done
    );

    modport dispatch (
        input  pkt_len, pkt_type, hdr_valid,
        output pkt_done
    );
endinterface

// payload fifo ports
interface ccu_fifo_if;
    import ccu_pkt_pkg::*;

    byte_t wdata;
    logic  wr_en;
    logic  rd_en;
    byte_t rdata;  // head entry, fall-through
    logic  full;
    logic  empty;

    modport fifo (
        input  wdata, wr_en, rd_en,
        output rdata, full, empty
    );

    modport writer (output wdata, wr_en, input full);

    modport reader (output rd_en, input rdata, empty);
endinterface

`default_nettype wire

// File: src/ccu_unpack_pkg.sv
`default_nettype none

package ccu_unpack_pkg;

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    // extra msb tells full from empty
    typedef logic [FIFO_AW:0] fifo_ptr_t;

    typedef enum logic [2:0] {
        HUNT,
        ID_LO,
        ID_HI,
        LEN_LO,
        LEN_HI,
        TYPE,
        PAYLOAD,
        WAIT_DONE
    } parse_state_e;

    typedef enum logic {
        IDLE,
        DRAIN
    } disp_state_e;

endpackage

`default_nettype wire

// File: src/ccu_pkt_pkg.sv
`default_nettype none

package ccu_pkt_pkg;

    // field widths on the wire
    localparam int BYTE_W = 8;
    localparam int ID_W   = 16;
    localparam int LEN_W  = 13;  // only the low bits of the 16-bit field
    localparam int TYPE_W = 8;

    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [ID_W-1:0]   pkt_id_t;
    typedef logic [LEN_W-1:0]  pkt_len_t;
    typedef logic [TYPE_W-1:0] pkt_type_t;

    localparam byte_t SYNC_BYTE = 8'h5A;  // start of packet

    // packet type codes
    localparam pkt_type_t TYPE_SYS_CTRL = 8'h00;  // system control
    localparam pkt_type_t TYPE_DATA_DAC = 8'h11;  // dac data, first byte is address
    localparam pkt_type_t TYPE_DATA_ADC = 8'h12;  // adc data, host bound
    localparam pkt_type_t TYPE_REQ_ADC  = 8'h21;  // adc read request
    localparam pkt_type_t TYPE_REQ_DAC  = 8'h22;  // dac read request

endpackage

`default_nettype wire
